// File: rtl/exu_pkg.sv
package exu_pkg;

    // alu operation codes, 11..15 are illegal
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SRL  = 4'd7,
        SLL  = 4'd8,
        SRA  = 4'd9,
        SLA  = 4'd10
    } alu_op_e;

    // branch compare codes, 6 and 7 are illegal
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5
    } branch_op_e;

    // word bits 3:0, 6:4 and 8
    typedef struct packed {
        logic       chain;
        branch_op_e branch_op;
        alu_op_e    alu_op;
    } exu_instr_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1
    } exu_state_e;

endpackage

// File: rtl/apb_pkg.sv
package apb_pkg;

    localparam int DATAWIDTH = 32;

    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [7:0]           paddr;
        logic [DATAWIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATAWIDTH-1:0] prdata;
        logic                 pready;
        logic                 pslverr;
    } apb_rsp_t;

    // register map
    typedef enum logic [7:0] {
        REG_A      = 8'h00,
        REG_B      = 8'h04,
        REG_INSTR  = 8'h08,
        REG_RESULT = 8'h0C,
        REG_FLAG   = 8'h10
    } exu_reg_e;

endpackage

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu #(
    parameter int DATAWIDTH   = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic [DATAWIDTH-1:0]   src_a_i,
    input  logic [DATAWIDTH-1:0]   src_b_i,
    input  exu_pkg::alu_op_e       alu_ctrl_i,
    input  exu_pkg::branch_op_e    branch_ctrl_i,
    input  logic [SHIFT_WIDTH-1:0] shift_i,
    output logic [DATAWIDTH-1:0]   alu_result_o,
    output logic                   zero_o
);

    logic signed [DATAWIDTH-1:0] src_a_signed;
    logic signed [DATAWIDTH-1:0] src_b_signed;
    logic                        lt_signed;
    logic                        lt_unsigned;
    logic                        equal;

    assign src_a_signed = src_a_i;
    assign src_b_signed = src_b_i;

    // shared compares for the slt ops and the branches
    assign lt_signed   = src_a_signed < src_b_signed;
    assign lt_unsigned = src_a_i < src_b_i;
    assign equal       = src_a_i == src_b_i;

    always_comb begin
        case (branch_ctrl_i)
            exu_pkg::BEQ: begin
                zero_o = equal;
            end
            exu_pkg::BNE: begin
                zero_o = !equal;
            end
            exu_pkg::BLT: begin
                zero_o = lt_signed;
            end
            exu_pkg::BGE: begin
                zero_o = !lt_signed;
            end
            exu_pkg::BLTU: begin
                zero_o = lt_unsigned;
            end
            exu_pkg::BGEU: begin
                zero_o = !lt_unsigned;
            end
            default: begin
                zero_o = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (alu_ctrl_i)
            exu_pkg::ADD: begin
                alu_result_o = src_a_i + src_b_i;
            end
            exu_pkg::SUB: begin
                alu_result_o = src_a_i - src_b_i;
            end
            exu_pkg::AND: begin
                alu_result_o = src_a_i & src_b_i;
            end
            exu_pkg::OR: begin
                alu_result_o = src_a_i | src_b_i;
            end
            exu_pkg::XOR: begin
                alu_result_o = src_a_i ^ src_b_i;
            end
            exu_pkg::SLT: begin
                alu_result_o = {{(DATAWIDTH-1){1'b0}}, lt_signed};
            end
            exu_pkg::SLTU: begin
                alu_result_o = {{(DATAWIDTH-1){1'b0}}, lt_unsigned};
            end
            exu_pkg::SRL: begin
                alu_result_o = src_a_i >> shift_i;
            end
            // arithmetic left shift is the same as logical
            exu_pkg::SLL, exu_pkg::SLA: begin
                alu_result_o = src_a_i << shift_i;
            end
            exu_pkg::SRA: begin
                alu_result_o = src_a_signed >>> shift_i;
            end
            default: begin
                alu_result_o = '0;
            end
        endcase
    end

endmodule

// File: rtl/exu_ctrl.sv
`timescale 1ns/1ns

module exu_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  apb_pkg::apb_req_t              apb_req_i,
    output apb_pkg::apb_rsp_t              apb_rsp_o,
    input  logic [apb_pkg::DATAWIDTH-1:0]  a_i,
    input  logic [apb_pkg::DATAWIDTH-1:0]  b_i,
    input  logic [apb_pkg::DATAWIDTH-1:0]  result_i,
    input  logic                           flag_i,
    input  exu_pkg::exu_instr_t            instr_q_i,
    output logic                           a_we_o,
    output logic                           b_we_o,
    output logic [apb_pkg::DATAWIDTH-1:0]  wdata_o,
    output logic                           launch_o,
    output exu_pkg::exu_instr_t            instr_o,
    output logic                           exec_o
);

    localparam int DW = apb_pkg::DATAWIDTH;

    exu_pkg::exu_state_e state_q;
    exu_pkg::exu_instr_t instr_d;
    logic                access;
    logic                wr;
    logic                mapped;
    logic                op_legal;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr     = access && apb_req_i.pwrite;

    assign mapped = apb_req_i.paddr inside {apb_pkg::REG_A, apb_pkg::REG_B,
        apb_pkg::REG_INSTR, apb_pkg::REG_RESULT, apb_pkg::REG_FLAG};

    assign instr_d.alu_op    = exu_pkg::alu_op_e'(apb_req_i.pwdata[3:0]);
    assign instr_d.branch_op = exu_pkg::branch_op_e'(apb_req_i.pwdata[6:4]);
    assign instr_d.chain     = apb_req_i.pwdata[8];

    assign op_legal = (apb_req_i.pwdata[3:0] <= exu_pkg::SLA)
                   && (apb_req_i.pwdata[6:4] <= exu_pkg::BGEU);

    // strobes live in the access cycle only
    assign a_we_o   = wr && (apb_req_i.paddr == apb_pkg::REG_A);
    assign b_we_o   = wr && (apb_req_i.paddr == apb_pkg::REG_B);
    assign launch_o = wr && (apb_req_i.paddr == apb_pkg::REG_INSTR) && op_legal;
    assign wdata_o  = apb_req_i.pwdata;

    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access && (!mapped
        || (wr && (apb_req_i.paddr == apb_pkg::REG_RESULT))
        || (wr && (apb_req_i.paddr == apb_pkg::REG_FLAG))
        || (wr && (apb_req_i.paddr == apb_pkg::REG_INSTR) && !op_legal));

    always_comb begin
        case (apb_req_i.paddr)
            apb_pkg::REG_A: begin
                apb_rsp_o.prdata = a_i;
            end
            apb_pkg::REG_B: begin
                apb_rsp_o.prdata = b_i;
            end
            apb_pkg::REG_INSTR: begin
                apb_rsp_o.prdata = {{(DW-9){1'b0}}, instr_q_i.chain, 1'b0,
                                    instr_q_i.branch_op, instr_q_i.alu_op};
            end
            apb_pkg::REG_RESULT: begin
                apb_rsp_o.prdata = result_i;
            end
            apb_pkg::REG_FLAG: begin
                apb_rsp_o.prdata = {{(DW-1){1'b0}}, flag_i};
            end
            default: begin
                apb_rsp_o.prdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= exu_pkg::IDLE;
            instr_o <= '0;
        end else begin
            case (state_q)
                exu_pkg::IDLE: begin
                    if (launch_o) begin
                        state_q <= exu_pkg::EXEC;
                        instr_o <= instr_d;
                    end
                end
                default: begin
                    state_q <= exu_pkg::IDLE;
                end
            endcase
        end
    end

    assign exec_o = (state_q == exu_pkg::EXEC);

    // host must leave the bus idle while the result is computed
    a_no_psel_in_exec: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exec_o |-> !apb_req_i.psel);

    // decoded fields must be enum members
    a_launch_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        launch_o |-> (instr_d.alu_op inside {exu_pkg::ADD, exu_pkg::SUB, exu_pkg::AND,
            exu_pkg::OR, exu_pkg::XOR, exu_pkg::SLT, exu_pkg::SLTU, exu_pkg::SRL,
            exu_pkg::SLL, exu_pkg::SRA, exu_pkg::SLA})
        && (instr_d.branch_op inside {exu_pkg::BEQ, exu_pkg::BNE, exu_pkg::BLT,
            exu_pkg::BGE, exu_pkg::BLTU, exu_pkg::BGEU}));

endmodule

// File: rtl/operand_file.sv
`timescale 1ns/1ns

module operand_file #(
    parameter int DATAWIDTH   = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   a_we_i,
    input  logic                   b_we_i,
    input  logic [DATAWIDTH-1:0]   wdata_i,
    input  logic                   commit_i,
    input  logic                   chain_i,
    input  logic [DATAWIDTH-1:0]   result_i,
    output logic [DATAWIDTH-1:0]   a_o,
    output logic [DATAWIDTH-1:0]   b_o,
    output logic [SHIFT_WIDTH-1:0] shamt_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            // chained result goes back into a
            if (commit_i && chain_i) begin
                a_o <= result_i;
            end else if (a_we_i) begin
                a_o <= wdata_i;
            end
            if (b_we_i) begin
                b_o <= wdata_i;
            end
        end
    end

    assign shamt_o = b_o[SHIFT_WIDTH-1:0];

    // a host write cannot collide with write-back
    a_no_we_on_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(a_we_i && commit_i));

endmodule

// File: rtl/result_unit.sv
`timescale 1ns/1ns

module result_unit (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          commit_i,
    input  exu_pkg::exu_instr_t           instr_i,
    input  logic [apb_pkg::DATAWIDTH-1:0] result_i,
    input  logic                          flag_i,
    output logic [apb_pkg::DATAWIDTH-1:0] result_o,
    output logic                          flag_o,
    output exu_pkg::exu_instr_t           instr_q_o
);

    // held until the next commit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o  <= '0;
            flag_o    <= 1'b0;
            instr_q_o <= '0;
        end else if (commit_i) begin
            result_o  <= result_i;
            flag_o    <= flag_i;
            instr_q_o <= instr_i;
        end
    end

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ns

module exu_top #(
    parameter int DATAWIDTH   = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  apb_pkg::apb_req_t apb_req_i,
    output apb_pkg::apb_rsp_t apb_rsp_o
);

    localparam int BUS_W = apb_pkg::DATAWIDTH;

    logic                   a_we;
    logic                   b_we;
    logic                   commit;
    logic [BUS_W-1:0]       wdata;
    exu_pkg::exu_instr_t    instr;
    exu_pkg::exu_instr_t    instr_q;
    logic [DATAWIDTH-1:0]   a_q;
    logic [DATAWIDTH-1:0]   b_q;
    logic [SHIFT_WIDTH-1:0] shamt;
    logic [DATAWIDTH-1:0]   alu_result;
    logic                   zero;
    logic [BUS_W-1:0]       result_q;
    logic                   flag_q;

    // launch is consumed inside the controller
    exu_ctrl u_ctrl (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .a_i       (BUS_W'(a_q)),
        .b_i       (BUS_W'(b_q)),
        .result_i  (result_q),
        .flag_i    (flag_q),
        .instr_q_i (instr_q),
        .a_we_o    (a_we),
        .b_we_o    (b_we),
        .wdata_o   (wdata),
        .launch_o  (),
        .instr_o   (instr),
        .exec_o    (commit)
    );

    operand_file #(
        .DATAWIDTH   (DATAWIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) u_operands (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .a_we_i   (a_we),
        .b_we_i   (b_we),
        .wdata_i  (DATAWIDTH'(wdata)),
        .commit_i (commit),
        .chain_i  (instr.chain),
        .result_i (alu_result),
        .a_o      (a_q),
        .b_o      (b_q),
        .shamt_o  (shamt)
    );

    alu #(
        .DATAWIDTH   (DATAWIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) u_alu (
        .src_a_i       (a_q),
        .src_b_i       (b_q),
        .alu_ctrl_i    (instr.alu_op),
        .branch_ctrl_i (instr.branch_op),
        .shift_i       (shamt),
        .alu_result_o  (alu_result),
        .zero_o        (zero)
    );

    result_unit u_result (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .commit_i  (commit),
        .instr_i   (instr),
        .result_i  (BUS_W'(alu_result)),
        .flag_i    (zero),
        .result_o  (result_q),
        .flag_o    (flag_q),
        .instr_q_o (instr_q)
    );

endmodule

// File: bench/exu_tb.sv
`timescale 1ns/1ns

module exu_tb;

    localparam int NUM_OPS     = 300;
    // worst case per op is 16 transfers of 3 cycles each
    localparam int MAX_XFERS   = NUM_OPS * 16 + 16;
    localparam int CYCLE_LIMIT = MAX_XFERS * 4 + 100;

    logic              clk;
    logic              rst_n;
    apb_pkg::apb_req_t req;
    apb_pkg::apb_rsp_t rsp;

    integer      seed = 32'hf39f_44f5;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] m_a;
    logic [31:0] m_b;
    logic [31:0] m_result;
    logic        m_flag;
    logic [31:0] m_instr;

    exu_top #(
        .DATAWIDTH   (32),
        .SHIFT_WIDTH (5)
    ) dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (req),
        .apb_rsp_o (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // often near the sign boundary or near zero
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = rand32();
        case (r[1:0])
            2'd0: rand_operand = 32'h7fff_fffc + {29'b0, r[4:2]};
            2'd1: rand_operand = 32'hffff_fffc + {29'b0, r[4:2]};
            default: rand_operand = rand32();
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic [3:0] op);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            exu_pkg::ADD: alu_model = a + b;
            exu_pkg::SUB: alu_model = a - b;
            exu_pkg::AND: alu_model = a & b;
            exu_pkg::OR: alu_model = a | b;
            exu_pkg::XOR: alu_model = a ^ b;
            exu_pkg::SLT: alu_model = {31'b0, $signed(a) < $signed(b)};
            exu_pkg::SLTU: alu_model = {31'b0, a < b};
            exu_pkg::SRL: alu_model = a >> sh;
            exu_pkg::SLL: alu_model = a << sh;
            exu_pkg::SRA: alu_model = $signed(a) >>> sh;
            exu_pkg::SLA: alu_model = a << sh;
            default: alu_model = 32'h0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [31:0] a, input logic [31:0] b,
                                          input logic [2:0] op);
        case (op)
            exu_pkg::BEQ: branch_model = (a == b);
            exu_pkg::BNE: branch_model = (a != b);
            exu_pkg::BLT: branch_model = ($signed(a) < $signed(b));
            exu_pkg::BGE: branch_model = !($signed(a) < $signed(b));
            exu_pkg::BLTU: branch_model = (a < b);
            exu_pkg::BGEU: branch_model = !(a < b);
            default: branch_model = 1'b0;
        endcase
    endfunction

    // setup, access, then one idle cycle for the execute slot
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= write;
        req.paddr   <= addr;
        req.pwdata  <= wdata;
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);
        while (!rsp.pready) begin
            @(negedge clk);
        end
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        @(posedge clk);
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
    endtask

    task automatic write_check(input logic [7:0] addr, input logic [31:0] wdata,
                               input logic expect_err, input string what);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
        check_value(32'(err), 32'(expect_err), {what, " pslverr"});
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        check_value(32'(err), 32'd0, {what, " pslverr"});
        check_value(rdata, expected, what);
    endtask

    task automatic check_outputs();
        read_check(apb_pkg::REG_RESULT, m_result, "REG_RESULT");
        read_check(apb_pkg::REG_FLAG, {31'b0, m_flag}, "REG_FLAG");
        read_check(apb_pkg::REG_INSTR, m_instr, "REG_INSTR");
    endtask

    task automatic check_all_regs();
        read_check(apb_pkg::REG_A, m_a, "REG_A");
        read_check(apb_pkg::REG_B, m_b, "REG_B");
        check_outputs();
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        logic [3:0]  alu_op;
        logic [2:0]  br_op;
        logic        chain;
        logic        prev_chain;
        req        = '0;
        rst_n      = 1'b0;
        m_a        = 32'h0;
        m_b        = 32'h0;
        m_result   = 32'h0;
        m_flag     = 1'b0;
        m_instr    = 32'h0;
        prev_chain = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        check_all_regs();

        for (int i = 0; i < NUM_OPS; i++) begin
            if (prev_chain) begin
                read_check(apb_pkg::REG_A, m_result, "chained REG_A");
            end else begin
                m_a = rand_operand();
                write_check(apb_pkg::REG_A, m_a, 1'b0, "write REG_A");
            end
            m_b = (rand32() % 32'd8 == 32'd0) ? m_a : rand_operand();
            write_check(apb_pkg::REG_B, m_b, 1'b0, "write REG_B");

            if (i % 8 == 3) begin
                r = rand32();
                if (r[0]) begin
                    word = {23'b0, r[1], 1'b0, 3'(r[23:16] % 8'd6), 4'd11 + 4'(r[15:8] % 8'd5)};
                end else begin
                    word = {23'b0, r[1], 1'b0, 3'd6 + {2'b0, r[2]}, 4'(r[31:24] % 8'd11)};
                end
                write_check(apb_pkg::REG_INSTR, word, 1'b1, "illegal instr");
                check_outputs();
            end

            if (i % 8 == 6) begin
                r = rand32();
                case (r[1:0])
                    2'd0: write_check(apb_pkg::REG_RESULT, rand32(), 1'b1, "write REG_RESULT");
                    2'd1: write_check(apb_pkg::REG_FLAG, rand32(), 1'b1, "write REG_FLAG");
                    default: begin
                        apb_xfer(r[2], 8'h14 + 8'(r[15:8] % 8'd224), rand32(), rdata, err);
                        check_value(32'(err), 32'd1, "unmapped access pslverr");
                    end
                endcase
                check_all_regs();
            end

            r      = rand32();
            alu_op = 4'(r[7:0] % 8'd11);
            br_op  = 3'(r[15:8] % 8'd6);
            chain  = (r[17:16] == 2'b00);
            // junk in the unused bits must not read back
            word = {rand32() & 32'hffff_fe80} | {23'b0, chain, 1'b0, br_op, alu_op};
            write_check(apb_pkg::REG_INSTR, word, 1'b0, "legal instr");
            m_result = alu_model(m_a, m_b, alu_op);
            m_flag   = branch_model(m_a, m_b, br_op);
            m_instr  = {23'b0, chain, 1'b0, br_op, alu_op};
            if (chain) begin
                m_a = m_result;
            end
            prev_chain = chain;
            check_outputs();
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/exu_pkg.sv
rtl/apb_pkg.sv
rtl/alu.sv
rtl/exu_ctrl.sv
rtl/operand_file.sv
rtl/result_unit.sv
rtl/exu_top.sv
bench/exu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the exu testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exu_tb -f src.f -o exu_sim \
    && ./obj_dir/exu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no result line in log"; exit 1; }
exit 0
